/* verilog/bpu_pkg.sv */
// branch update definitions
package bpu_pkg;

    // branch kinds
    localparam logic [2:0] NOT_JUMP      = 3'd0;
    localparam logic [2:0] DIRECT_JUMP   = 3'd1; // conditional direct
    localparam logic [2:0] CALL          = 3'd2;
    localparam logic [2:0] RET           = 3'd3;
    localparam logic [2:0] INDIRECT_JUMP = 3'd4;
    localparam logic [2:0] OTHER_JUMP    = 3'd5; // unconditional direct

    localparam int PC_W     = 30; // word address, byte addr [31:2]
    localparam int BH_W     = 14;
    localparam int CHOICE_W = 2;

    localparam int BUF_DEPTH = 6;
    localparam int PTR_W     = $clog2(BUF_DEPTH);
    localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

    // pdc fields, ex fields, pc, paired flag
    localparam int REC_W = (1 + 3 + PC_W + CHOICE_W + BH_W) + (1 + 3 + PC_W) + PC_W + 1;

    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // one instruction word, two branch formats
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i16;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_word_u;

endpackage

/* verilog/branch_kind_decode.sv */
// branch kind decoder
`timescale 1ns/100ps
module branch_kind_decode (
    input  bpu_pkg::inst_word_u          inst,
    output logic [2:0]                   kind,
    output logic [bpu_pkg::PC_W-1:0]     offset
);

    logic [5:0]  opcode;
    logic        is_long;    // b / bl use the 26-bit form
    logic [25:0] offs26;
    logic [15:0] offs16;

    assign opcode = inst.i16.opcode;
    assign offs26 = {inst.i26.offs_hi, inst.i26.offs_lo};
    assign offs16 = inst.i16.offs16;

    always_comb begin
        kind    = bpu_pkg::NOT_JUMP;
        is_long = 1'b0;
        case (opcode)
            bpu_pkg::OP_JIRL: begin
                // jirl r0, r1, 0 style return
                if (inst.i16.rd == 5'd0 && inst.i16.rj == 5'd1) begin
                    kind = bpu_pkg::RET;
                end else begin
                    kind = bpu_pkg::INDIRECT_JUMP;
                end
            end
            bpu_pkg::OP_B: begin
                kind    = bpu_pkg::OTHER_JUMP;
                is_long = 1'b1;
            end
            bpu_pkg::OP_BL: begin
                kind    = bpu_pkg::CALL;
                is_long = 1'b1;
            end
            bpu_pkg::OP_BEQ,
            bpu_pkg::OP_BNE,
            bpu_pkg::OP_BLT,
            bpu_pkg::OP_BGE,
            bpu_pkg::OP_BLTU,
            bpu_pkg::OP_BGEU: begin
                kind = bpu_pkg::DIRECT_JUMP;
            end
            default: begin
                kind = bpu_pkg::NOT_JUMP;
            end
        endcase
    end

    // sign extend to word offset
    always_comb begin
        if (is_long) begin
            offset = {{(bpu_pkg::PC_W - 26){offs26[25]}}, offs26};
        end else begin
            offset = {{(bpu_pkg::PC_W - 16){offs16[15]}}, offs16};
        end
    end

endmodule

/* verilog/branch_resolve.sv */
// branch resolve for one lane
`timescale 1ns/100ps
module branch_resolve (
    input  logic [2:0]                kind,
    input  logic [bpu_pkg::PC_W-1:0]  offset,
    input  logic [bpu_pkg::PC_W-1:0]  pc,
    input  logic                      cond_true,
    input  logic [31:0]               reg_target,
    input  logic                      taken_pdc,
    input  logic [bpu_pkg::PC_W-1:0]  npc_pdc,
    output logic                      taken_ex,
    output logic [bpu_pkg::PC_W-1:0]  npc_ex,
    output logic                      mispredict
);

    logic [bpu_pkg::PC_W-1:0] target;
    logic [bpu_pkg::PC_W-1:0] seq_pc;

    assign seq_pc = pc + bpu_pkg::PC_W'(1);

    always_comb begin
        taken_ex = 1'b0;
        target   = pc + offset;
        case (kind)
            bpu_pkg::DIRECT_JUMP: begin
                taken_ex = cond_true;
            end
            bpu_pkg::CALL,
            bpu_pkg::OTHER_JUMP: begin
                taken_ex = 1'b1;
            end
            bpu_pkg::RET,
            bpu_pkg::INDIRECT_JUMP: begin
                taken_ex = 1'b1;
                target   = reg_target[31:2]; // word target from rj
            end
            default: begin
                taken_ex = 1'b0;
            end
        endcase
    end

    assign npc_ex = taken_ex ? target : seq_pc;

    // direction wrong, or right direction to wrong place
    assign mispredict = (taken_pdc != taken_ex) ||
                        (taken_ex && (npc_pdc != npc_ex));

endmodule

/* verilog/ex_buffer.sv */
// resolved branch queue and update merge
`timescale 1ns/100ps
module ex_buffer (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          stall,
    input  logic [1:0]                    inst_valid,

    input  logic                          taken_pdc_0,
    input  logic [2:0]                    kind_pdc_0,
    input  logic [bpu_pkg::PC_W-1:0]      npc_pdc_0,
    input  logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc_0,
    input  logic [bpu_pkg::BH_W-1:0]      bh_pdc_0,
    input  logic                          taken_ex_0,
    input  logic [2:0]                    kind_ex_0,
    input  logic [bpu_pkg::PC_W-1:0]      npc_ex_0,
    input  logic [bpu_pkg::PC_W-1:0]      pc_0,
    input  logic                          mispredict_0,

    input  logic                          taken_pdc_1,
    input  logic [2:0]                    kind_pdc_1,
    input  logic [bpu_pkg::PC_W-1:0]      npc_pdc_1,
    input  logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc_1,
    input  logic [bpu_pkg::BH_W-1:0]      bh_pdc_1,
    input  logic                          taken_ex_1,
    input  logic [2:0]                    kind_ex_1,
    input  logic [bpu_pkg::PC_W-1:0]      npc_ex_1,
    input  logic [bpu_pkg::PC_W-1:0]      pc_1,

    output logic                          update_en,
    output logic                          taken_pdc,
    output logic [2:0]                    kind_pdc,
    output logic [bpu_pkg::PC_W-1:0]      npc_pdc,
    output logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc,
    output logic [bpu_pkg::BH_W-1:0]      bh_pdc,
    output logic                          taken_ex,
    output logic [2:0]                    kind_ex,
    output logic [bpu_pkg::PC_W-1:0]      npc_ex,
    output logic [bpu_pkg::PC_W-1:0]      pc_ex,
    output logic                          buffer_full
);

    logic [bpu_pkg::REC_W-1:0] mem [bpu_pkg::BUF_DEPTH];

    logic [bpu_pkg::PTR_W-1:0] head;
    logic [bpu_pkg::PTR_W-1:0] tail;
    logic [bpu_pkg::CNT_W-1:0] count;

    logic       push0;
    logic       push1;
    logic       paired_in;
    logic [1:0] push_n;
    logic [1:0] pop_n;
    logic       empty;

    logic [bpu_pkg::REC_W-1:0] rec0;
    logic [bpu_pkg::REC_W-1:0] rec1;
    logic [bpu_pkg::REC_W-1:0] head_rec;
    logic [bpu_pkg::REC_W-1:0] next_rec;

    // head record fields
    logic                          h_taken_pdc;
    logic [2:0]                    h_kind_pdc;
    logic [bpu_pkg::PC_W-1:0]      h_npc_pdc;
    logic [bpu_pkg::CHOICE_W-1:0]  h_choice_pdc;
    logic [bpu_pkg::BH_W-1:0]      h_bh_pdc;
    logic                          h_taken_ex;
    logic [2:0]                    h_kind_ex;
    logic [bpu_pkg::PC_W-1:0]      h_npc_ex;
    logic [bpu_pkg::PC_W-1:0]      h_pc;
    logic                          h_paired;

    // second half of a pair, only the ex part matters
    logic                          n_taken_ex;
    logic [2:0]                    n_kind_ex;
    logic [bpu_pkg::PC_W-1:0]      n_npc_ex;

    logic                          m_taken_ex;
    logic [2:0]                    m_kind_ex;
    logic [bpu_pkg::PC_W-1:0]      m_npc_ex;

    function automatic logic [bpu_pkg::PTR_W-1:0] ptr_add(
        input logic [bpu_pkg::PTR_W-1:0] p,
        input logic [1:0]                n
    );
        logic [bpu_pkg::PTR_W:0] s;
        s = {1'b0, p} + (bpu_pkg::PTR_W + 1)'(n);
        if (s >= (bpu_pkg::PTR_W + 1)'(bpu_pkg::BUF_DEPTH)) begin
            s = s - (bpu_pkg::PTR_W + 1)'(bpu_pkg::BUF_DEPTH);
        end
        return s[bpu_pkg::PTR_W-1:0];
    endfunction

    function automatic logic [2:0] merge_kind(input logic [2:0] a, input logic [2:0] b);
        if (a == bpu_pkg::DIRECT_JUMP || b == bpu_pkg::DIRECT_JUMP) begin
            return bpu_pkg::DIRECT_JUMP;
        end else if (a == bpu_pkg::CALL || b == bpu_pkg::CALL) begin
            return bpu_pkg::CALL;
        end else if (a == bpu_pkg::RET || b == bpu_pkg::RET) begin
            return bpu_pkg::RET;
        end else if (a == bpu_pkg::INDIRECT_JUMP || b == bpu_pkg::INDIRECT_JUMP) begin
            return bpu_pkg::INDIRECT_JUMP;
        end else if (a == bpu_pkg::OTHER_JUMP || b == bpu_pkg::OTHER_JUMP) begin
            return bpu_pkg::OTHER_JUMP;
        end
        return bpu_pkg::NOT_JUMP;
    endfunction

    // intake, lane 1 dropped behind a lane 0 mispredict
    assign push0     = !stall && inst_valid[0];
    assign push1     = !stall && inst_valid[1] && !mispredict_0;
    assign paired_in = push0 && push1;
    assign push_n    = {1'b0, push0} + {1'b0, push1};

    assign rec0 = {taken_pdc_0, kind_pdc_0, npc_pdc_0, choice_pdc_0, bh_pdc_0,
                   taken_ex_0, kind_ex_0, npc_ex_0, pc_0, paired_in};
    assign rec1 = {taken_pdc_1, kind_pdc_1, npc_pdc_1, choice_pdc_1, bh_pdc_1,
                   taken_ex_1, kind_ex_1, npc_ex_1, pc_1, 1'b0};

    always_ff @(posedge clk) begin
        if (push0) begin
            mem[tail] <= rec0;
        end
        if (push1) begin
            mem[ptr_add(tail, {1'b0, push0})] <= rec1;
        end
    end

    // drain side
    assign empty    = (count == '0);
    assign head_rec = mem[head];
    assign next_rec = mem[ptr_add(head, 2'd1)];

    assign {h_taken_pdc, h_kind_pdc, h_npc_pdc, h_choice_pdc, h_bh_pdc,
            h_taken_ex, h_kind_ex, h_npc_ex, h_pc, h_paired} = head_rec;
    assign {n_taken_ex, n_kind_ex, n_npc_ex} = next_rec[1 + bpu_pkg::PC_W +: 4 + bpu_pkg::PC_W];

    assign pop_n = empty ? 2'd0 : (h_paired ? 2'd2 : 2'd1);

    always_comb begin
        if (h_paired) begin
            m_taken_ex = h_taken_ex | n_taken_ex;
            m_kind_ex  = merge_kind(h_kind_ex, n_kind_ex);
            m_npc_ex   = h_taken_ex ? h_npc_ex : n_npc_ex;
        end else begin
            m_taken_ex = h_taken_ex;
            m_kind_ex  = h_kind_ex;
            m_npc_ex   = h_npc_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= ptr_add(head, pop_n);
            tail  <= ptr_add(tail, push_n);
            count <= count + bpu_pkg::CNT_W'(push_n) - bpu_pkg::CNT_W'(pop_n);
        end
    end

    assign buffer_full = count > bpu_pkg::CNT_W'(bpu_pkg::BUF_DEPTH - 2); // < 2 free

    // registered update, fields hold between pulses
    always_ff @(posedge clk) begin
        if (!rstn) begin
            update_en  <= 1'b0;
            taken_pdc  <= 1'b0;
            kind_pdc   <= '0;
            npc_pdc    <= '0;
            choice_pdc <= '0;
            bh_pdc     <= '0;
            taken_ex   <= 1'b0;
            kind_ex    <= '0;
            npc_ex     <= '0;
            pc_ex      <= '0;
        end else begin
            update_en <= !empty;
            if (!empty) begin
                taken_pdc  <= h_taken_pdc;
                kind_pdc   <= h_kind_pdc;
                npc_pdc    <= h_npc_pdc;
                choice_pdc <= h_choice_pdc;
                bh_pdc     <= h_bh_pdc;
                taken_ex   <= m_taken_ex;
                kind_ex    <= m_kind_ex;
                npc_ex     <= m_npc_ex;
                pc_ex      <= h_pc;
            end
        end
    end

endmodule

/* verilog/bp_update_top.sv */
// branch predictor update path
`timescale 1ns/100ps
module bp_update_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [1:0]                    inst_valid,
    input  logic                          stall,

    input  logic [31:0]                   inst_0,
    input  logic [bpu_pkg::PC_W-1:0]      pc_0,
    input  logic                          cond_true_0,
    input  logic [31:0]                   reg_target_0,
    input  logic                          taken_pdc_0,
    input  logic [2:0]                    kind_pdc_0,
    input  logic [bpu_pkg::PC_W-1:0]      npc_pdc_0,
    input  logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc_0,
    input  logic [bpu_pkg::BH_W-1:0]      bh_pdc_0,

    input  logic [31:0]                   inst_1,
    input  logic [bpu_pkg::PC_W-1:0]      pc_1,
    input  logic                          cond_true_1,
    input  logic [31:0]                   reg_target_1,
    input  logic                          taken_pdc_1,
    input  logic [2:0]                    kind_pdc_1,
    input  logic [bpu_pkg::PC_W-1:0]      npc_pdc_1,
    input  logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc_1,
    input  logic [bpu_pkg::BH_W-1:0]      bh_pdc_1,

    output logic                          update_en,
    output logic                          taken_pdc,
    output logic [2:0]                    kind_pdc,
    output logic [bpu_pkg::PC_W-1:0]      npc_pdc,
    output logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc,
    output logic [bpu_pkg::BH_W-1:0]      bh_pdc,
    output logic                          taken_ex,
    output logic [2:0]                    kind_ex,
    output logic [bpu_pkg::PC_W-1:0]      npc_ex,
    output logic [bpu_pkg::PC_W-1:0]      pc_ex,
    output logic                          buffer_full
);

    logic [2:0]               kind_dec_0;
    logic [2:0]               kind_dec_1;
    logic [bpu_pkg::PC_W-1:0] offset_0;
    logic [bpu_pkg::PC_W-1:0] offset_1;
    logic                     taken_ex_0;
    logic                     taken_ex_1;
    logic [bpu_pkg::PC_W-1:0] npc_ex_0;
    logic [bpu_pkg::PC_W-1:0] npc_ex_1;
    logic                     mispredict_0;

    branch_kind_decode u_dec_0 (.inst(inst_0), .kind(kind_dec_0), .offset(offset_0));
    branch_kind_decode u_dec_1 (.inst(inst_1), .kind(kind_dec_1), .offset(offset_1));

    branch_resolve u_res_0 (
        .kind(kind_dec_0), .offset(offset_0), .pc(pc_0),
        .cond_true(cond_true_0), .reg_target(reg_target_0),
        .taken_pdc(taken_pdc_0), .npc_pdc(npc_pdc_0),
        .taken_ex(taken_ex_0), .npc_ex(npc_ex_0), .mispredict(mispredict_0)
    );

    // lane 1 mispredict goes to redirect logic outside this block
    branch_resolve u_res_1 (
        .kind(kind_dec_1), .offset(offset_1), .pc(pc_1),
        .cond_true(cond_true_1), .reg_target(reg_target_1),
        .taken_pdc(taken_pdc_1), .npc_pdc(npc_pdc_1),
        .taken_ex(taken_ex_1), .npc_ex(npc_ex_1), .mispredict()
    );

    ex_buffer u_buf (
        .clk(clk), .rstn(rstn), .stall(stall), .inst_valid(inst_valid),
        .taken_pdc_0(taken_pdc_0), .kind_pdc_0(kind_pdc_0), .npc_pdc_0(npc_pdc_0),
        .choice_pdc_0(choice_pdc_0), .bh_pdc_0(bh_pdc_0),
        .taken_ex_0(taken_ex_0), .kind_ex_0(kind_dec_0), .npc_ex_0(npc_ex_0),
        .pc_0(pc_0), .mispredict_0(mispredict_0),
        .taken_pdc_1(taken_pdc_1), .kind_pdc_1(kind_pdc_1), .npc_pdc_1(npc_pdc_1),
        .choice_pdc_1(choice_pdc_1), .bh_pdc_1(bh_pdc_1),
        .taken_ex_1(taken_ex_1), .kind_ex_1(kind_dec_1), .npc_ex_1(npc_ex_1),
        .pc_1(pc_1),
        .update_en(update_en), .taken_pdc(taken_pdc), .kind_pdc(kind_pdc),
        .npc_pdc(npc_pdc), .choice_pdc(choice_pdc), .bh_pdc(bh_pdc),
        .taken_ex(taken_ex), .kind_ex(kind_ex), .npc_ex(npc_ex), .pc_ex(pc_ex),
        .buffer_full(buffer_full)
    );

endmodule

/* verif/tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/100ps
module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // 8 ns period
        end
    end

    // low for 10 edges, released just after an edge
    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

/* verif/bp_update_assert.sv */
// ex_buffer protocol checks
`timescale 1ns/100ps
module bp_update_assert (
    input logic       clk,
    input logic       rstn,
    input logic       stall,
    input logic [1:0] inst_valid,
    input logic       buffer_full,
    input logic       update_en
);

    logic [3:0] packs_held; // packs taken in, not yet seen on update_en

    always_ff @(posedge clk) begin
        if (!rstn) begin
            packs_held <= '0;
        end else begin
            packs_held <= packs_held + 4'(!stall && inst_valid[0]) - 4'(update_en);
        end
    end

    // upstream holds stall while full
    a_no_intake_full: assert property (@(posedge clk) disable iff (!rstn)
        buffer_full |-> (stall || !inst_valid[0]))
        else $error("intake while buffer full");

    a_idle_after_reset: assert property (@(posedge clk) !rstn |=> !update_en)
        else $error("update_en high in the cycle after reset");

    // nothing buffered, so nothing to emit
    a_no_update_empty: assert property (@(posedge clk) disable iff (!rstn)
        packs_held == 4'(update_en) |=> !update_en)
        else $error("update_en after an empty cycle");

    a_lane_order: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid[1] |-> inst_valid[0])
        else $error("lane 1 valid without lane 0");

endmodule

bind ex_buffer bp_update_assert u_assert (
    .clk(clk), .rstn(rstn), .stall(stall), .inst_valid(inst_valid),
    .buffer_full(buffer_full), .update_en(update_en)
);

/* verif/tb_top.sv */
// branch update testbench
`timescale 1ns/100ps
module tb_top;

    typedef struct packed {
        logic                          taken_pdc;
        logic [2:0]                    kind_pdc;
        logic [bpu_pkg::PC_W-1:0]      npc_pdc;
        logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc;
        logic [bpu_pkg::BH_W-1:0]      bh_pdc;
        logic                          taken_ex;
        logic [2:0]                    kind_ex;
        logic [bpu_pkg::PC_W-1:0]      npc_ex;
        logic [bpu_pkg::PC_W-1:0]      pc_ex;
        logic [1:0]                    nrec; // records behind this update
    } upd_t;

    logic                          clk;
    logic                          rstn;
    logic [1:0]                    inst_valid;
    logic                          stall;
    logic [31:0]                   inst [2];
    logic [bpu_pkg::PC_W-1:0]      pc [2];
    logic                          cond_true [2];
    logic [31:0]                   reg_target [2];
    logic                          taken_p [2];
    logic [2:0]                    kind_p [2];
    logic [bpu_pkg::PC_W-1:0]      npc_p [2];
    logic [bpu_pkg::CHOICE_W-1:0]  choice_p [2];
    logic [bpu_pkg::BH_W-1:0]      bh_p [2];

    logic                          update_en;
    logic                          taken_pdc;
    logic [2:0]                    kind_pdc;
    logic [bpu_pkg::PC_W-1:0]      npc_pdc;
    logic [bpu_pkg::CHOICE_W-1:0]  choice_pdc;
    logic [bpu_pkg::BH_W-1:0]      bh_pdc;
    logic                          taken_ex;
    logic [2:0]                    kind_ex;
    logic [bpu_pkg::PC_W-1:0]      npc_ex;
    logic [bpu_pkg::PC_W-1:0]      pc_ex;
    logic                          buffer_full;

    upd_t upd_q [$]; // expected updates in order
    upd_t pend;      // update from the pack waiting for the next edge
    logic pend_valid;
    int   n_upd;

    tb_clk_gen u_clk (.clk(clk), .rstn(rstn));

    bp_update_top uut (
        .clk(clk), .rstn(rstn), .inst_valid(inst_valid), .stall(stall),
        .inst_0(inst[0]), .pc_0(pc[0]), .cond_true_0(cond_true[0]),
        .reg_target_0(reg_target[0]), .taken_pdc_0(taken_p[0]), .kind_pdc_0(kind_p[0]),
        .npc_pdc_0(npc_p[0]), .choice_pdc_0(choice_p[0]), .bh_pdc_0(bh_p[0]),
        .inst_1(inst[1]), .pc_1(pc[1]), .cond_true_1(cond_true[1]),
        .reg_target_1(reg_target[1]), .taken_pdc_1(taken_p[1]), .kind_pdc_1(kind_p[1]),
        .npc_pdc_1(npc_p[1]), .choice_pdc_1(choice_p[1]), .bh_pdc_1(bh_p[1]),
        .update_en(update_en), .taken_pdc(taken_pdc), .kind_pdc(kind_pdc),
        .npc_pdc(npc_pdc), .choice_pdc(choice_pdc), .bh_pdc(bh_pdc),
        .taken_ex(taken_ex), .kind_ex(kind_ex), .npc_ex(npc_ex), .pc_ex(pc_ex),
        .buffer_full(buffer_full)
    );

    task automatic abort_run(input string why);
        $display("Some tests failed");
        $fatal(1, why);
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
            abort_run("stopped at the first mismatch");
        end
    endtask

    function automatic logic [2:0] ref_kind(input logic [31:0] w);
        if (w[31:26] == bpu_pkg::OP_JIRL) begin
            return (w[4:0] == 5'd0 && w[9:5] == 5'd1) ? bpu_pkg::RET : bpu_pkg::INDIRECT_JUMP;
        end else if (w[31:26] == bpu_pkg::OP_B) begin
            return bpu_pkg::OTHER_JUMP;
        end else if (w[31:26] == bpu_pkg::OP_BL) begin
            return bpu_pkg::CALL;
        end else if (w[31:26] >= bpu_pkg::OP_BEQ && w[31:26] <= bpu_pkg::OP_BGEU) begin
            return bpu_pkg::DIRECT_JUMP;
        end
        return bpu_pkg::NOT_JUMP;
    endfunction

    // {taken, next pc} of lane n
    function automatic logic [bpu_pkg::PC_W:0] resolve_ref(input int n);
        logic [2:0]               k;
        logic                     t;
        logic [bpu_pkg::PC_W-1:0] off;
        logic [bpu_pkg::PC_W-1:0] npc;
        k = ref_kind(inst[n]);
        t = (k == bpu_pkg::DIRECT_JUMP) ? cond_true[n] : (k != bpu_pkg::NOT_JUMP);
        if (k == bpu_pkg::CALL || k == bpu_pkg::OTHER_JUMP) begin
            off = {{4{inst[n][9]}}, inst[n][9:0], inst[n][25:10]};
        end else begin
            off = {{14{inst[n][25]}}, inst[n][25:10]};
        end
        npc = (k == bpu_pkg::RET || k == bpu_pkg::INDIRECT_JUMP) ? reg_target[n][31:2]
                                                                  : pc[n] + off;
        if (!t) begin
            npc = pc[n] + bpu_pkg::PC_W'(1);
        end
        return {t, npc};
    endfunction

    function automatic logic [2:0] pick_kind(input logic [2:0] a, input logic [2:0] b);
        logic [2:0] order [5];
        order = '{bpu_pkg::DIRECT_JUMP, bpu_pkg::CALL, bpu_pkg::RET,
                  bpu_pkg::INDIRECT_JUMP, bpu_pkg::OTHER_JUMP};
        foreach (order[i]) begin
            if (a == order[i] || b == order[i]) begin
                return order[i];
            end
        end
        return bpu_pkg::NOT_JUMP;
    endfunction

    function automatic upd_t make_upd(input logic pair);
        upd_t                   u;
        logic [bpu_pkg::PC_W:0] r0;
        logic [bpu_pkg::PC_W:0] r1;
        r0 = resolve_ref(0);
        r1 = resolve_ref(1);
        u = '{taken_p[0], kind_p[0], npc_p[0], choice_p[0], bh_p[0],
              r0[bpu_pkg::PC_W], ref_kind(inst[0]), r0[bpu_pkg::PC_W-1:0], pc[0], 2'd1};
        if (pair) begin
            u.taken_ex = r0[bpu_pkg::PC_W] | r1[bpu_pkg::PC_W];
            u.kind_ex  = pick_kind(u.kind_ex, ref_kind(inst[1]));
            u.npc_ex   = r0[bpu_pkg::PC_W] ? r0[bpu_pkg::PC_W-1:0] : r1[bpu_pkg::PC_W-1:0];
            u.nrec     = 2'd2;
        end
        return u;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 6))
            0: w[31:26] = $urandom_range(0, 1) ? 6'($urandom_range(0, 18))
                                               : 6'($urandom_range(28, 63)); // non-branch
            1: w = {bpu_pkg::OP_JIRL, w[25:10], 5'd1, 5'd0}; // return form
            2: w[31:26] = bpu_pkg::OP_JIRL;
            3: w[31:26] = bpu_pkg::OP_B;
            4: w[31:26] = bpu_pkg::OP_BL;
            default: w[31:26] = 6'($urandom_range(22, 27));
        endcase
        return w;
    endfunction

    task automatic gen_lane(input int n);
        logic [bpu_pkg::PC_W:0] r;
        inst[n]       = rand_word();
        cond_true[n]  = 1'($urandom_range(0, 1));
        reg_target[n] = $urandom;
        choice_p[n]   = bpu_pkg::CHOICE_W'($urandom);
        bh_p[n]       = bpu_pkg::BH_W'($urandom);
        r             = resolve_ref(n);
        taken_p[n]    = r[bpu_pkg::PC_W];
        kind_p[n]     = ref_kind(inst[n]);
        npc_p[n]      = r[bpu_pkg::PC_W-1:0];
        case ($urandom_range(0, 5))
            0: taken_p[n] = !r[bpu_pkg::PC_W]; // wrong direction
            1: npc_p[n] = npc_p[n] + bpu_pkg::PC_W'($urandom_range(1, 64));
            2: kind_p[n] = 3'($urandom_range(0, 5));
            default: kind_p[n] = kind_p[n];
        endcase
    endtask

    task automatic drive_pack(input logic active);
        logic [bpu_pkg::PC_W:0] r0;
        logic                   mis0;
        int                     sel;
        sel        = $urandom_range(0, 4);
        inst_valid = (!active || sel == 0) ? 2'b00 : (sel == 1) ? 2'b01 : 2'b11;
        stall      = ($urandom_range(0, 3) == 0) || buffer_full;
        pc[0]      = bpu_pkg::PC_W'($urandom);
        pc[1]      = pc[0] + bpu_pkg::PC_W'(1);
        gen_lane(0);
        gen_lane(1);
        r0   = resolve_ref(0);
        mis0 = (taken_p[0] != r0[bpu_pkg::PC_W]) ||
               (r0[bpu_pkg::PC_W] && npc_p[0] != r0[bpu_pkg::PC_W-1:0]);
        pend_valid = !stall && inst_valid[0];
        pend       = make_upd(inst_valid[1] && !mis0); // lane 1 flushed behind a mispredict
    endtask

    task automatic compare_update(input string tag, input upd_t e);
        check({tag, " taken_pdc"}, e.taken_pdc, taken_pdc);
        check({tag, " kind_pdc"}, e.kind_pdc, kind_pdc);
        check({tag, " npc_pdc"}, e.npc_pdc, npc_pdc);
        check({tag, " choice_pdc"}, e.choice_pdc, choice_pdc);
        check({tag, " bh_pdc"}, e.bh_pdc, bh_pdc);
        check({tag, " taken_ex"}, e.taken_ex, taken_ex);
        check({tag, " kind_ex"}, e.kind_ex, kind_ex);
        check({tag, " npc_ex"}, e.npc_ex, npc_ex);
        check({tag, " pc_ex"}, e.pc_ex, pc_ex);
    endtask

    // one edge of the model, drain before intake
    task automatic edge_step();
        upd_t e;
        int   cnt;
        check("update_en", upd_q.size() != 0, update_en);
        if (upd_q.size() != 0) begin
            e = upd_q.pop_front();
            compare_update($sformatf("update %0d", n_upd), e);
            n_upd++;
        end else if (n_upd == 0) begin
            compare_update("idle after reset", '0);
        end
        if (pend_valid) begin
            upd_q.push_back(pend);
        end
        pend_valid = 1'b0;
        cnt = 0;
        foreach (upd_q[i]) begin
            cnt += upd_q[i].nrec;
        end
        check("buffer_full", (bpu_pkg::BUF_DEPTH - cnt) < 2, buffer_full); // free slots
    endtask

    initial begin
        int waited;
        inst_valid = 2'b00;
        stall      = 1'b0;
        for (int n = 0; n < 2; n++) begin
            inst[n]       = '0;
            pc[n]         = '0;
            cond_true[n]  = 1'b0;
            reg_target[n] = '0;
            taken_p[n]    = 1'b0;
            kind_p[n]     = '0;
            npc_p[n]      = '0;
            choice_p[n]   = '0;
            bh_p[n]       = '0;
        end
        pend_valid = 1'b0;
        n_upd      = 0;
        void'($urandom(32'h24db_4af9));

        waited = 0;
        while (rstn !== 1'b1 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (rstn !== 1'b1) begin
            abort_run("reset was never released");
        end
        #1;
        edge_step();

        drive_pack(1'b1);
        repeat (600) begin
            @(posedge clk);
            #1;
            edge_step();
            drive_pack(1'b1);
        end

        // idle lanes, stall still random
        waited = 0;
        while ((upd_q.size() != 0 || pend_valid) && waited < 40) begin
            @(posedge clk);
            #1;
            edge_step();
            drive_pack(1'b0);
            waited++;
        end
        if (upd_q.size() != 0 || pend_valid) begin
            abort_run("expected updates were not drained in time");
        end else begin
            @(posedge clk);
            #1;
            edge_step();
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* flist.f */
verilog/bpu_pkg.sv
verilog/branch_kind_decode.sv
verilog/branch_resolve.sv
verilog/ex_buffer.sv
verilog/bp_update_top.sv
verif/tb_clk_gen.sv
verif/bp_update_assert.sv
verif/tb_top.sv

/* Bender.yml */
package:
  name: bp_update

sources:
  - verilog/bpu_pkg.sv
  - verilog/branch_kind_decode.sv
  - verilog/branch_resolve.sv
  - verilog/ex_buffer.sv
  - verilog/bp_update_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/bp_update_assert.sv
      - verif/tb_top.sv
